// File: verif/icache_input.txt
# name kind addr addr2 cacop_mode cacop_way expect_hit (addresses in hex)
# cacop takes tag and index from addr, pair reads addr then addr2 back to back
cold_miss        read   12345678 00000000 0 0 0
same_line_hit    read   12345670 00000000 0 0 1
second_tag_miss  read   ABCDE674 00000000 0 0 0
first_tag_hit    read   1234567C 00000000 0 0 1
second_tag_hit   read   ABCDE67C 00000000 0 0 1
b2b_same_index   pair   12345674 ABCDE670 0 0 1
cacop_idx_init   cacop  00000670 00000000 0 0 0
init_a_miss      read   12345678 00000000 0 0 0
init_b_miss      read   ABCDE678 00000000 0 0 0
cacop_way1       cacop  00000670 00000000 1 1 0
way0_still_hit   read   12345670 00000000 0 0 1
way1_miss        read   ABCDE670 00000000 0 0 0
cacop_hit_a      cacop  12345670 00000000 2 0 0
b_still_hit      read   ABCDE674 00000000 0 0 1
a_miss           read   1234567C 00000000 0 0 0
other_index_miss read   00F00010 00000000 0 0 0
other_index_hit  read   00F0001C 00000000 0 0 1
b2b_two_index    pair   00F00014 ABCDE678 0 0 1

// File: flist.f
+incdir+design
design/icache_pkg.sv
design/icache_array_if.sv
design/icache_ram.sv
design/icache_ctrl.sv
design/icache.sv
verif/icache_assert.sv
verif/icache_tb.sv

// File: run.sh
#!/bin/sh
# build and run the icache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps -f flist.f \
  --top-module icache_tb -Mdir obj_dir -o icache_sim \
  && ./obj_dir/icache_sim +verilator+error+limit+100 > sim.log 2>&1 \
  || { echo "build or run failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q '^\*\*\* PASSED \*\*\*$' sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: verif/icache_tb.sv
`timescale 1ns/10ps

module icache_tb;

  localparam logic [31:0] MEM_KEY = 32'hC0DE_0000;  // memory word = address xor key

  logic        clk;
  logic        resetn;
  logic        valid;
  logic [7:0]  index;
  logic [19:0] tag;
  logic [3:0]  offset;
  logic        addr_ok;
  logic        data_ok;
  logic [31:0] rdata;
  logic        cacop_en;
  logic [1:0]  cacop_mode;
  logic [19:0] cacop_tag;
  logic [7:0]  cacop_index;
  logic        cacop_way;
  logic        cacop_ok;
  logic        rd_req;
  logic [31:0] rd_addr;
  logic        rd_rdy;
  logic        ret_valid;
  logic        ret_last;
  logic [31:0] ret_data;

  logic [31:0] lfsr_q = 32'h9631_0752;
  int          n_tests;
  int          n_errors;
  string       cur_name;

  // test table loaded from the data file
  string       q_name[$];
  string       q_kind[$];
  logic [31:0] q_addr[$];
  logic [31:0] q_addr2[$];
  int          q_mode[$];
  int          q_way[$];
  int          q_hit[$];

  icache dut_i (.*);

  always #20 clk = ~clk;

  // fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [3:0] take_bits(input int n);
    logic [3:0] r;
    logic       fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[2:0], fb};
    end
    return r;
  endfunction

  task automatic next_edge();
    @(posedge clk);
    #2;
  endtask

  // addr_ok sampled mid-cycle, returns just after the accepting edge
  task automatic wait_addr_ok();
    @(negedge clk);
    while (!addr_ok) begin
      next_edge();
      @(negedge clk);
    end
    next_edge();
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
      n_errors++;
    end
  endtask

  task automatic read_word(input string name, input logic [31:0] addr, input int exp_hit);
    int          lat;
    logic        saw_req;
    logic [31:0] req_addr;
    lat      = 1;
    saw_req  = 1'b0;
    req_addr = '0;
    next_edge();
    {tag, index, offset} = addr;
    valid = 1'b1;
    wait_addr_ok();
    valid = 1'b0;
    @(negedge clk);
    while (!data_ok) begin
      if (rd_req && !saw_req) begin
        saw_req  = 1'b1;
        req_addr = rd_addr;
      end
      next_edge();
      @(negedge clk);
      lat++;
    end
    check(name, {addr[31:2], 2'b00} ^ MEM_KEY, rdata);
    check(name, exp_hit, saw_req ? 0 : 1);
    if (exp_hit != 0)
      check(name, 1, lat);  // one cycle after acceptance
    else
      check(name, {addr[31:4], 4'h0}, req_addr);  // line base
  endtask

  // second request rides on the data_ok cycle of the first
  task automatic read_pair(input string name, input logic [31:0] a0, input logic [31:0] a1);
    next_edge();
    {tag, index, offset} = a0;
    valid = 1'b1;
    wait_addr_ok();
    {tag, index, offset} = a1;
    @(negedge clk);
    check(name, 1, 32'(data_ok));
    check(name, 1, 32'(addr_ok));
    check(name, {a0[31:2], 2'b00} ^ MEM_KEY, rdata);
    next_edge();
    valid = 1'b0;
    @(negedge clk);
    check(name, 1, 32'(data_ok));
    check(name, {a1[31:2], 2'b00} ^ MEM_KEY, rdata);
  endtask

  task automatic cache_op(input string name, input int mode, input logic [31:0] addr,
                          input int way);
    int ok_cycle;
    ok_cycle = 0;
    wait_addr_ok();  // DUT idle
    cacop_en    = 1'b1;
    cacop_mode  = 2'(mode);
    cacop_tag   = addr[31:12];
    cacop_index = addr[11:4];
    cacop_way   = way[0];
    @(negedge clk);
    if (cacop_ok)
      ok_cycle = 1;
    next_edge();
    cacop_en = 1'b0;
    @(negedge clk);
    if (cacop_ok && ok_cycle == 0)
      ok_cycle = 2;
    check(name, (mode == 2) ? 2 : 1, ok_cycle);  // mode 2 answers from LOOKUP
  endtask

  // memory model with random rd_rdy delay and beat gaps
  always begin : mem_model
    logic [31:0] base;
    @(negedge clk);
    if (resetn && rd_req) begin
      base = rd_addr;
      next_edge();
      repeat (take_bits(2)) next_edge();
      rd_rdy = 1'b1;
      next_edge();
      rd_rdy = 1'b0;
      for (int b = 0; b < 4; b++) begin
        repeat (take_bits(2)) next_edge();
        ret_valid = 1'b1;
        ret_last  = (b == 3);
        ret_data  = (base + 32'(4 * b)) ^ MEM_KEY;
        next_edge();
        ret_valid = 1'b0;
        ret_last  = 1'b0;
      end
    end
  end

  initial begin : watchdog
    wait (n_tests > 0);
    repeat (n_tests * 64) @(posedge clk);
    $display("watchdog expired in test %s, the DUT never gave data_ok or cacop_ok", cur_name);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin : main
    int          fd;
    int          n;
    int          failed_tests;
    int          errs_before;
    string       line;
    string       name;
    string       kind;
    logic [31:0] a;
    logic [31:0] a2;
    int          mode;
    int          way;
    int          hit;
    failed_tests = 0;
    n_errors     = 0;
    n_tests      = 0;
    clk          = 1'b0;
    {resetn, valid, tag, index, offset} = '0;
    {cacop_en, cacop_mode, cacop_tag, cacop_index, cacop_way} = '0;
    {rd_rdy, ret_valid, ret_last, ret_data} = '0;
    fd = $fopen("verif/icache_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file verif/icache_input.txt");
      n_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.substr(0, 0) != "#") begin
          n = $sscanf(line, "%s %s %h %h %d %d %d", name, kind, a, a2, mode, way, hit);
          if (n == 7) begin
            q_name.push_back(name);
            q_kind.push_back(kind);
            q_addr.push_back(a);
            q_addr2.push_back(a2);
            q_mode.push_back(mode);
            q_way.push_back(way);
            q_hit.push_back(hit);
          end
        end
      end
      $fclose(fd);
    end
    repeat (8) next_edge();
    resetn  = 1'b1;
    n_tests = q_name.size();
    foreach (q_name[i]) begin
      cur_name    = q_name[i];
      errs_before = n_errors;
      if (q_kind[i] == "read")
        read_word(q_name[i], q_addr[i], q_hit[i]);
      else if (q_kind[i] == "pair")
        read_pair(q_name[i], q_addr[i], q_addr2[i]);
      else if (q_kind[i] == "cacop")
        cache_op(q_name[i], q_mode[i], q_addr[i], q_way[i]);
      else begin
        $display("test %s has an unknown kind %s", q_name[i], q_kind[i]);
        n_errors++;
      end
      if (n_errors == errs_before) begin
        $display("%s: ok", q_name[i]);
      end else begin
        $display("%s: failed", q_name[i]);
        failed_tests++;
      end
    end
    $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
             n_tests, failed_tests, n_errors, dut_i.u_assert.fired);
    if (failed_tests == 0 && n_errors == 0 && dut_i.u_assert.fired == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: verif/icache_assert.sv
`timescale 1ns/10ps

module icache_assert (
  input logic                    clk,
  input logic                    resetn,
  input icache_pkg::main_state_t state,
  input logic                    rd_req,
  input logic                    rd_rdy,
  input logic                    data_ok,
  input logic                    cacop_ok
);

  int unsigned fired = 0;

  // request held until the memory takes it
  a_req_held: assert property (@(posedge clk) disable iff (!resetn)
    rd_req && !rd_rdy |=> rd_req)
    else begin
      fired++;
      $error("rd_req dropped before rd_rdy");
    end

  a_no_data_idle: assert property (@(posedge clk) disable iff (!resetn)
    state == icache_pkg::IDLE |-> !data_ok)
    else begin
      fired++;
      $error("data_ok high in IDLE");
    end

  a_ok_excl: assert property (@(posedge clk) disable iff (!resetn)
    !(cacop_ok && data_ok))
    else begin
      fired++;
      $error("cacop_ok and data_ok high together");
    end

  a_reset_req: assert property (@(posedge clk) !resetn |=> !rd_req)  // sync reset
    else begin
      fired++;
      $error("rd_req high after reset");
    end

endmodule

bind icache icache_assert u_assert (
  .clk      (clk),
  .resetn   (resetn),
  .state    (u_ctrl.state),
  .rd_req   (rd_req),
  .rd_rdy   (rd_rdy),
  .data_ok  (data_ok),
  .cacop_ok (cacop_ok)
);

// File: design/icache.sv
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache (
  input  logic                        clk,
  input  logic                        resetn,
  input  logic                        valid,
  input  icache_pkg::index_t          index,
  input  icache_pkg::tag_t            tag,
  input  logic [`ICACHE_OFFSET_W-1:0] offset,
  output logic                        addr_ok,
  output logic                        data_ok,
  output icache_pkg::word_t           rdata,
  input  logic                        cacop_en,
  input  logic [1:0]                  cacop_mode,
  input  icache_pkg::tag_t            cacop_tag,
  input  icache_pkg::index_t          cacop_index,
  input  logic                        cacop_way,
  output logic                        cacop_ok,
  output logic                        rd_req,
  output icache_pkg::word_t           rd_addr,
  input  logic                        rd_rdy,
  input  logic                        ret_valid,
  input  logic                        ret_last,
  input  icache_pkg::word_t           ret_data
);

  icache_array_if arr ();

  icache_ctrl u_ctrl (
    .clk         (clk),
    .resetn      (resetn),
    .valid       (valid),
    .index       (index),
    .tag         (tag),
    .offset      (offset),
    .addr_ok     (addr_ok),
    .data_ok     (data_ok),
    .rdata       (rdata),
    .cacop_en    (cacop_en),
    .cacop_mode  (cacop_mode),
    .cacop_tag   (cacop_tag),
    .cacop_index (cacop_index),
    .cacop_way   (cacop_way),
    .cacop_ok    (cacop_ok),
    .rd_req      (rd_req),
    .rd_addr     (rd_addr),
    .rd_rdy      (rd_rdy),
    .ret_valid   (ret_valid),
    .ret_last    (ret_last),
    .ret_data    (ret_data),
    .arr         (arr.ctrl)
  );

  // one tag RAM and one data RAM per way
  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
    icache_ram #(.payload_t(icache_pkg::tag_t)) u_tag_ram (
      .clk   (clk),
      .we    (arr.tag_we[w]),
      .raddr ({icache_pkg::word_sel_t'(0), arr.rd_index}),  // low entries only
      .waddr ({icache_pkg::word_sel_t'(0), arr.wr_index}),
      .wdata (arr.wtag),
      .rdata (arr.rtag[w])
    );

    icache_ram #(.payload_t(icache_pkg::word_t)) u_data_ram (
      .clk   (clk),
      .we    (arr.data_we[w]),
      .raddr ({arr.rd_index, arr.rd_word}),
      .waddr ({arr.wr_index, arr.wr_word}),
      .wdata (arr.wdata),
      .rdata (arr.rword[w])
    );
  end

endmodule

// File: design/icache_ctrl.sv
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_ctrl (
  input  logic                        clk,
  input  logic                        resetn,
  input  logic                        valid,
  input  icache_pkg::index_t          index,
  input  icache_pkg::tag_t            tag,
  input  logic [`ICACHE_OFFSET_W-1:0] offset,
  output logic                        addr_ok,
  output logic                        data_ok,
  output icache_pkg::word_t           rdata,
  input  logic                        cacop_en,
  input  logic [1:0]                  cacop_mode,
  input  icache_pkg::tag_t            cacop_tag,
  input  icache_pkg::index_t          cacop_index,
  input  logic                        cacop_way,
  output logic                        cacop_ok,
  output logic                        rd_req,
  output icache_pkg::word_t           rd_addr,
  input  logic                        rd_rdy,
  input  logic                        ret_valid,
  input  logic                        ret_last,
  input  icache_pkg::word_t           ret_data,
  icache_array_if.ctrl                arr
);

  icache_pkg::main_state_t state;

  // request buffer
  icache_pkg::tag_t      req_tag;
  icache_pkg::index_t    req_index;
  icache_pkg::word_sel_t req_word;
  logic                  req_cacop;   // cacop hit mode in flight

  // valid bits kept in flops so reset empties the cache
  logic [`ICACHE_WAYS-1:0][(1 << `ICACHE_INDEX_W)-1:0] valid_q;

  icache_pkg::way_vec_t  line_valid;
  icache_pkg::way_vec_t  hit;
  icache_pkg::way_vec_t  victim_oh;
  icache_pkg::word_t     hit_word;
  icache_pkg::word_sel_t in_word;
  icache_pkg::word_sel_t beat_cnt;
  logic                  lookup_hit;
  logic                  victim;
  logic [7:0]            lfsr;
  logic                  accept_rd;
  logic                  accept_cop;
  logic                  cop_hit_mode;
  logic                  refill_beat;
  logic                  refill_last;

  assign in_word      = offset[`ICACHE_OFFSET_W-1:2];
  assign cop_hit_mode = (cacop_mode == `CACOP_HIT);

  // cacop wins over a read in IDLE
  assign accept_cop = (state == icache_pkg::IDLE) & cacop_en;
  assign accept_rd  = valid & addr_ok;

  assign refill_beat = (state == icache_pkg::REFILL) & ret_valid;
  assign refill_last = refill_beat & ret_last;

  // tag compare against both ways
  always_comb begin
    hit_word = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      line_valid[w] = valid_q[w][req_index];
      hit[w]        = line_valid[w] & (arr.rtag[w] == req_tag);
      if (hit[w]) begin
        hit_word = arr.rword[w];
      end
    end
  end

  assign lookup_hit = |hit;

  always_comb begin
    victim_oh         = '0;
    victim_oh[victim] = 1'b1;
  end

  assign addr_ok = ((state == icache_pkg::IDLE) & ~cacop_en) |
                   ((state == icache_pkg::LOOKUP) & ~req_cacop & lookup_hit);

  // hit in LOOKUP or the critical beat during refill
  assign data_ok = ((state == icache_pkg::LOOKUP) & ~req_cacop & lookup_hit) |
                   (refill_beat & (beat_cnt == req_word));
  assign rdata   = (state == icache_pkg::REFILL) ? ret_data : hit_word;

  assign cacop_ok = (accept_cop & ~cop_hit_mode) |
                    ((state == icache_pkg::LOOKUP) & req_cacop);

  assign rd_req  = (state == icache_pkg::REPLACE);
  assign rd_addr = {req_tag, req_index, {`ICACHE_OFFSET_W{1'b0}}};  // line base

  // RAM read address, new request or held buffer
  assign arr.rd_index = accept_cop ? cacop_index : (accept_rd ? index : req_index);
  assign arr.rd_word  = accept_rd ? in_word : req_word;

  // refill writes go to the victim way
  assign arr.wr_index = req_index;
  assign arr.wr_word  = beat_cnt;
  assign arr.tag_we   = refill_last ? victim_oh : '0;
  assign arr.data_we  = refill_beat ? victim_oh : '0;
  assign arr.wtag     = req_tag;
  assign arr.wdata    = ret_data;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= icache_pkg::IDLE;
      req_cacop <= 1'b0;
      beat_cnt  <= '0;
    end else begin
      case (state)
        icache_pkg::IDLE: begin
          if (accept_cop) begin
            req_cacop <= cop_hit_mode;
            if (cop_hit_mode) begin
              state <= icache_pkg::LOOKUP;  // tag has to be read first
            end
          end else if (accept_rd) begin
            req_cacop <= 1'b0;
            state     <= icache_pkg::LOOKUP;
          end
        end
        icache_pkg::LOOKUP: begin
          if (req_cacop) begin
            req_cacop <= 1'b0;
            state     <= icache_pkg::IDLE;
          end else if (!lookup_hit) begin
            state <= icache_pkg::MISS;
          end else if (!valid) begin
            state <= icache_pkg::IDLE;
          end
        end
        icache_pkg::MISS: begin
          state <= icache_pkg::REPLACE;
        end
        icache_pkg::REPLACE: begin
          if (rd_rdy) begin
            state    <= icache_pkg::REFILL;
            beat_cnt <= '0;
          end
        end
        icache_pkg::REFILL: begin
          if (ret_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (ret_last) begin
              state <= icache_pkg::IDLE;
            end
          end
        end
        default: state <= icache_pkg::IDLE;
      endcase
    end
  end

  // payload of the request buffer
  always_ff @(posedge clk) begin
    if (accept_cop) begin
      req_tag   <= cacop_tag;
      req_index <= cacop_index;
    end else if (accept_rd) begin
      req_tag   <= tag;
      req_index <= index;
      req_word  <= in_word;
    end
  end

  // invalid way first, else the random bit
  always_ff @(posedge clk) begin
    if (state == icache_pkg::MISS) begin
      if (!line_valid[0]) begin
        victim <= 1'b0;
      end else if (!line_valid[1]) begin
        victim <= 1'b1;
      end else begin
        victim <= lfsr[7];
      end
    end
  end

  // fibonacci LFSR, taps 7 5 3 2
  always_ff @(posedge clk) begin
    if (!resetn) begin
      lfsr <= `ICACHE_LFSR_SEED;
    end else begin
      lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[3] ^ lfsr[2]};
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      valid_q <= '0;
    end else if (accept_cop && cacop_mode == `CACOP_IDX_INIT) begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        valid_q[w][cacop_index] <= 1'b0;
      end
    end else if (accept_cop && cacop_mode == `CACOP_IDX_WAY) begin
      valid_q[cacop_way][cacop_index] <= 1'b0;
    end else if (state == icache_pkg::LOOKUP && req_cacop) begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        if (hit[w]) begin
          valid_q[w][req_index] <= 1'b0;  // matching way only
        end
      end
    end else if (refill_last) begin
      valid_q[victim][req_index] <= 1'b1;
    end
  end

endmodule

// File: design/icache_ram.sv
`timescale 1ns/10ps

module icache_ram #(
  parameter type payload_t = icache_pkg::word_t
) (
  input  logic                  clk,
  input  logic                  we,
  input  icache_pkg::ram_addr_t raddr,
  input  icache_pkg::ram_addr_t waddr,
  input  payload_t              wdata,
  output payload_t              rdata
);

  // block RAM style storage
  payload_t mem [(1 << $bits(icache_pkg::ram_addr_t))];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read, old data on a same-address write
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

// File: design/icache_array_if.sv
`timescale 1ns/10ps
`include "icache_settings.svh"

interface icache_array_if;

  // read side, result one clock later
  icache_pkg::index_t    rd_index;
  icache_pkg::word_sel_t rd_word;

  // refill write side
  icache_pkg::index_t    wr_index;
  icache_pkg::word_sel_t wr_word;
  icache_pkg::way_vec_t  tag_we;
  icache_pkg::way_vec_t  data_we;
  icache_pkg::tag_t      wtag;
  icache_pkg::word_t     wdata;

  // one RAM output per way
  icache_pkg::tag_t  [`ICACHE_WAYS-1:0] rtag;
  icache_pkg::word_t [`ICACHE_WAYS-1:0] rword;

  modport ctrl (
    output rd_index, rd_word, wr_index, wr_word,
    output tag_we, data_we, wtag, wdata,
    input  rtag, rword
  );

  modport ram (
    input  rd_index, rd_word, wr_index, wr_word,
    input  tag_we, data_we, wtag, wdata,
    output rtag, rword
  );

endinterface

// File: design/icache_pkg.sv
`include "icache_settings.svh"

package icache_pkg;

  typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0] index_t;

  // word within a line
  typedef logic [$clog2(`ICACHE_WORDS)-1:0] word_sel_t;

  typedef logic [31:0] word_t;

  typedef logic [`ICACHE_WAYS-1:0] way_vec_t;  // one bit per way

  // data RAM address is {index, word}
  typedef logic [`ICACHE_INDEX_W+$clog2(`ICACHE_WORDS)-1:0] ram_addr_t;

  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    LOOKUP  = 3'd1,
    MISS    = 3'd2,
    REPLACE = 3'd3,  // waiting for the memory to take rd_req
    REFILL  = 3'd4
  } main_state_t;

endpackage

// File: design/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// two ways of 256 sets with 16-byte lines
`define ICACHE_WAYS       2
`define ICACHE_INDEX_W    8
`define ICACHE_TAG_W      20
`define ICACHE_OFFSET_W   4
`define ICACHE_WORDS      4     // words per line, also burst beats

// victim LFSR start value
`define ICACHE_LFSR_SEED  8'h59

// cacop mode codes
`define CACOP_IDX_INIT    2'd0  // both ways of an index
`define CACOP_IDX_WAY     2'd1  // one way picked by the way bit
`define CACOP_HIT         2'd2  // way whose tag matches

`endif
